// ==== hdl/alu_consts.svh ====
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// --------------------------------------------------------------------------
// Datapath widths
// --------------------------------------------------------------------------

// Operand and result width
`define ALU_DATA_WIDTH 8

// AXI4-Lite bus widths
`define AXI_ADDR_WIDTH 5
`define AXI_DATA_WIDTH 32

// --------------------------------------------------------------------------
// Register map, byte offsets
// --------------------------------------------------------------------------

// Operand registers
`define REG_A      5'h00
`define REG_B      5'h04
// Opcode write starts the operation
`define REG_CTRL   5'h08
// Read only
`define REG_RESULT 5'h0C
// V N C Z, z in bit 0
`define REG_FLAGS  5'h10

`endif

// ==== hdl/aluPkg.sv ====
`include "alu_consts.svh"

package aluPkg;

    // Operation codes, E and F unused
    typedef enum logic [3:0] {
        opAdd  = 4'h0,
        opSub  = 4'h1,
        opAnd  = 4'h2,
        opOr   = 4'h3,
        opXor  = 4'h4,
        opAdc  = 4'h5,
        opSbc  = 4'h6,
        opCmp  = 4'h7,
        opShl  = 4'h8,
        opShr  = 4'h9,
        opNand = 4'hA,
        opNor  = 4'hB,
        opXnor = 4'hC,
        opAsr  = 4'hD
    } aluOpE;

    // Flag order V N C Z, z is bit 0
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flagsT;

    typedef struct packed {
        logic [`ALU_DATA_WIDTH-1:0] a;
        logic [`ALU_DATA_WIDTH-1:0] b;
        aluOpE                      op;
        flagsT                      flagsIn;
    } aluReqT;

    // Partial result of one unit
    typedef struct packed {
        logic [`ALU_DATA_WIDTH-1:0] y;
        logic                       c;
        logic                       v;
    } unitResT;

    typedef struct packed {
        logic [`ALU_DATA_WIDTH-1:0] y;
        flagsT                      flags;
    } aluRespT;

    // Master driven AXI4-Lite signals
    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] awAddr;
        logic                       awValid;
        logic [`AXI_DATA_WIDTH-1:0] wData;
        logic [3:0]                 wStrb;
        logic                       wValid;
        logic                       bReady;
        logic [`AXI_ADDR_WIDTH-1:0] arAddr;
        logic                       arValid;
        logic                       rReady;
    } axiReqT;

    // Slave driven AXI4-Lite signals
    typedef struct packed {
        logic                       awReady;
        logic                       wReady;
        logic [1:0]                 bResp;
        logic                       bValid;
        logic                       arReady;
        logic [`AXI_DATA_WIDTH-1:0] rData;
        logic [1:0]                 rResp;
        logic                       rValid;
    } axiRespT;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // Codes 0 to D are defined, the rest illegal
    function automatic logic opLegal(input logic [3:0] code);
        return code <= 4'(opAsr);
    endfunction

endpackage

// ==== hdl/aluArith.sv ====
`timescale 1ns/100ps

`include "alu_consts.svh"

// --------------------------------------------------------------------------
// Add/subtract unit
// --------------------------------------------------------------------------
module aluArith import aluPkg::*; (
    input  aluReqT  req,
    output unitResT res
);

    localparam int W = `ALU_DATA_WIDTH;

    // Second operand after optional inversion
    logic [W-1:0] bEff;
    logic         carryIn;
    // One extra bit for carry out
    logic [W:0]   sum;

    // Subtraction as A + ~B + 1
    // Carry out then means no borrow
    always_comb begin
        case (req.op)
            opAdd: begin
                bEff    = req.b;
                carryIn = 1'b0;
            end
            opSub, opCmp: begin
                bEff    = ~req.b;
                carryIn = 1'b1;
            end
            // Chained add, stored carry in
            opAdc: begin
                bEff    = req.b;
                carryIn = req.flagsIn.c;
            end
            // Chained subtract, carry set means no borrow
            opSbc: begin
                bEff    = ~req.b;
                carryIn = req.flagsIn.c;
            end
            // Logic and shift codes, result unused
            default: begin
                bEff    = req.b;
                carryIn = 1'b0;
            end
        endcase
    end

    assign sum = {1'b0, req.a} + {1'b0, bEff} + {{W{1'b0}}, carryIn};

    assign res.y = sum[W-1:0];
    assign res.c = sum[W];

    // Two's complement overflow
    // Same sign on both addends, different sign on the sum
    // Uses bEff so subtract gets the right sign too
    assign res.v = (req.a[W-1] == bEff[W-1]) && (sum[W-1] != req.a[W-1]);

endmodule

// ==== hdl/aluLogic.sv ====
`timescale 1ns/100ps

`include "alu_consts.svh"

// --------------------------------------------------------------------------
// Bitwise and shift unit
// --------------------------------------------------------------------------
module aluLogic import aluPkg::*; (
    input  aluReqT  req,
    output unitResT res
);

    localparam int W = `ALU_DATA_WIDTH;

    logic [W-1:0] y;
    // Bit shifted out, zero for bitwise ops
    logic         shiftOut;

    always_comb begin
        shiftOut = 1'b0;
        case (req.op)
            opAnd:  y = req.a & req.b;
            opOr:   y = req.a | req.b;
            opXor:  y = req.a ^ req.b;
            opNand: y = ~(req.a & req.b);
            opNor:  y = ~(req.a | req.b);
            opXnor: y = ~(req.a ^ req.b);
            // One bit left, MSB out to carry
            opShl: begin
                y        = {req.a[W-2:0], 1'b0};
                shiftOut = req.a[W-1];
            end
            // Logical right, zero fill
            opShr: begin
                y        = {1'b0, req.a[W-1:1]};
                shiftOut = req.a[0];
            end
            // Arithmetic right, sign kept
            opAsr: begin
                y        = {req.a[W-1], req.a[W-1:1]};
                shiftOut = req.a[0];
            end
            // Arithmetic codes handled elsewhere
            default: y = '0;
        endcase
    end

    assign res.y = y;
    assign res.c = shiftOut;
    // No overflow from logic or shifts
    assign res.v = 1'b0;

endmodule

// ==== hdl/aluCore.sv ====
`timescale 1ns/100ps

`include "alu_consts.svh"

// --------------------------------------------------------------------------
// ALU core, two units side by side plus flag forming
// --------------------------------------------------------------------------
module aluCore import aluPkg::*; (
    input  aluReqT  req,
    output aluRespT resp
);

    localparam int W = `ALU_DATA_WIDTH;

    unitResT arithRes;
    unitResT logicRes;
    unitResT selRes;
    logic    isArith;

    aluArith u_aluArith (
        .req (req),
        .res (arithRes)
    );

    aluLogic u_aluLogic (
        .req (req),
        .res (logicRes)
    );

    // Operation class
    always_comb begin
        case (req.op)
            opAdd, opSub, opAdc, opSbc, opCmp: isArith = 1'b1;
            default:                           isArith = 1'b0;
        endcase
    end

    assign selRes = isArith ? arithRes : logicRes;

    // Compare keeps A on y
    // Flags below still come from the difference
    assign resp.y = (req.op == opCmp) ? req.a : selRes.y;

    assign resp.flags.v = selRes.v;
    assign resp.flags.c = selRes.c;
    assign resp.flags.n = selRes.y[W-1];
    assign resp.flags.z = (selRes.y == '0);

    // Register block must filter bad codes before they get here
    // Skipped while the opcode source is still unknown
    always_comb begin
        if (!$isunknown(req.op)) begin
            assert (opLegal(req.op))
            else $error("aluCore: illegal opcode %h", req.op);
        end
    end

endmodule

// ==== hdl/aluAxiRegs.sv ====
`timescale 1ns/100ps

`include "alu_consts.svh"

// --------------------------------------------------------------------------
// AXI4-Lite slave and register file
// --------------------------------------------------------------------------
module aluAxiRegs import aluPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  axiReqT  busReq,
    output axiRespT busResp,
    output aluReqT  coreReq,
    input  aluRespT coreResp
);

    localparam int W  = `ALU_DATA_WIDTH;
    localparam int DW = `AXI_DATA_WIDTH;

    // Register file
    logic [W-1:0]  aReg;
    logic [W-1:0]  bReg;
    logic [W-1:0]  resultReg;
    aluOpE         opReg;
    flagsT         flagsReg;

    // Channel state
    logic          awReadyQ;
    logic          bValidQ;
    logic          arReadyQ;
    logic          rValidQ;
    logic [1:0]    bRespQ;
    logic [1:0]    rRespQ;
    logic [DW-1:0] rDataQ;

    logic          wrFire;
    logic          rdFire;
    logic          wrStrb0;
    logic [3:0]    wrCode;
    logic          wrCodeLegal;
    logic          wrErr;
    logic          ctrlLoad;
    logic          rdErr;
    logic [DW-1:0] rdData;

    assign wrFire      = awReadyQ && busReq.awValid && busReq.wValid;
    assign rdFire      = arReadyQ && busReq.arValid;
    assign wrStrb0     = busReq.wStrb[0];
    assign wrCode      = busReq.wData[3:0];
    assign wrCodeLegal = opLegal(wrCode);

    // ----------------------------------------------------------------------
    // Write decode
    // ----------------------------------------------------------------------
    always_comb begin
        case (busReq.awAddr)
            `REG_A, `REG_B, `REG_FLAGS: wrErr = 1'b0;
            // Bad code only matters when the byte is written
            `REG_CTRL: wrErr = wrStrb0 && !wrCodeLegal;
            // Result is read only, rest unmapped
            default: wrErr = 1'b1;
        endcase
    end

    // Operation runs on the incoming opcode at the write edge
    assign ctrlLoad = wrFire && (busReq.awAddr == `REG_CTRL) && wrStrb0 && wrCodeLegal;

    assign coreReq.a       = aReg;
    assign coreReq.b       = bReg;
    assign coreReq.flagsIn = flagsReg;
    // Otherwise the last legal op, keeps the core input clean
    assign coreReq.op      = ctrlLoad ? aluOpE'(wrCode) : opReg;

    // ----------------------------------------------------------------------
    // Read decode
    // ----------------------------------------------------------------------
    always_comb begin
        rdErr  = 1'b0;
        rdData = '0;
        case (busReq.arAddr)
            `REG_A:      rdData[W-1:0] = aReg;
            `REG_B:      rdData[W-1:0] = bReg;
            `REG_CTRL:   rdData[3:0]   = opReg;
            `REG_RESULT: rdData[W-1:0] = resultReg;
            `REG_FLAGS:  rdData[3:0]   = flagsReg;
            default:     rdErr         = 1'b1;
        endcase
    end

    // Handshake state
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            awReadyQ <= 1'b0;
            bValidQ  <= 1'b0;
            arReadyQ <= 1'b0;
            rValidQ  <= 1'b0;
        end else begin
            // AW and W taken together, one cycle pulse
            awReadyQ <= !awReadyQ && busReq.awValid && busReq.wValid && !bValidQ;
            if (wrFire) begin
                bValidQ <= 1'b1;
            end else if (busReq.bReady) begin
                bValidQ <= 1'b0;
            end
            // Read side, ready whenever no response waits
            if (rdFire) begin
                rValidQ  <= 1'b1;
                arReadyQ <= 1'b0;
            end else if (rValidQ && busReq.rReady) begin
                rValidQ  <= 1'b0;
                arReadyQ <= 1'b1;
            end else if (!rValidQ) begin
                arReadyQ <= 1'b1;
            end
        end
    end

    // Register file updates
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aReg      <= '0;
            bReg      <= '0;
            resultReg <= '0;
            opReg     <= opAdd;
            flagsReg  <= '0;
        end else if (wrFire && wrStrb0 && !wrErr) begin
            case (busReq.awAddr)
                `REG_A:     aReg     <= busReq.wData[W-1:0];
                `REG_B:     bReg     <= busReq.wData[W-1:0];
                // Preset, mainly for carry in
                `REG_FLAGS: flagsReg <= flagsT'(busReq.wData[3:0]);
                `REG_CTRL: begin
                    opReg    <= aluOpE'(wrCode);
                    flagsReg <= coreResp.flags;
                    // Compare only touches flags
                    if (aluOpE'(wrCode) != opCmp) begin
                        resultReg <= coreResp.y;
                    end
                end
                default: ;
            endcase
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (wrFire) begin
            bRespQ <= wrErr ? respSlvErr : respOkay;
        end
        if (rdFire) begin
            rDataQ <= rdData;
            rRespQ <= rdErr ? respSlvErr : respOkay;
        end
    end

    assign busResp.awReady = awReadyQ;
    assign busResp.wReady  = awReadyQ;
    assign busResp.bResp   = bRespQ;
    assign busResp.bValid  = bValidQ;
    assign busResp.arReady = arReadyQ;
    assign busResp.rData   = rDataQ;
    assign busResp.rResp   = rRespQ;
    assign busResp.rValid  = rValidQ;

    // ----------------------------------------------------------------------
    // Protocol checks
    // ----------------------------------------------------------------------
    // Stalled write response holds
    assert property (@(posedge clk) disable iff (!arstN)
        bValidQ && !busReq.bReady |=> bValidQ && $stable(bRespQ))
    else $error("aluAxiRegs: write response dropped or changed");

    // Stalled read data holds
    assert property (@(posedge clk) disable iff (!arstN)
        rValidQ && !busReq.rReady |=> rValidQ && $stable(rDataQ))
    else $error("aluAxiRegs: read response dropped or changed");

    // No new write while a response is pending
    assert property (@(posedge clk) disable iff (!arstN)
        bValidQ |-> !awReadyQ)
    else $error("aluAxiRegs: awReady with pending bValid");

endmodule

// ==== hdl/aluTop.sv ====
`timescale 1ns/100ps

// --------------------------------------------------------------------------
// Coprocessor top, bus registers feeding the ALU core
// --------------------------------------------------------------------------
module aluTop import aluPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  axiReqT  busReq,
    output axiRespT busResp
);

    // Operands and opcode to the core
    aluReqT  coreReq;
    // Result and flags back
    aluRespT coreResp;

    aluAxiRegs u_aluAxiRegs (
        .clk      (clk),
        .arstN    (arstN),
        .busReq   (busReq),
        .busResp  (busResp),
        .coreReq  (coreReq),
        .coreResp (coreResp)
    );

    // Zero latency, captured by the register block
    aluCore u_aluCore (
        .req  (coreReq),
        .resp (coreResp)
    );

endmodule

// ==== tb/tbClkGen.sv ====
`timescale 1ns/100ps

// --------------------------------------------------------------------------
// Clock and reset source for the testbench
// --------------------------------------------------------------------------
module tbClkGen (
    output logic clk,
    output logic arstN
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset low for 5 rising edges
    initial begin
        arstN <= 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

// ==== tb/aluTopTb.sv ====
`timescale 1ns/100ps

`include "alu_consts.svh"

module aluTopTb import aluPkg::*; ();

    localparam int TIMEOUT = 200;

    logic    clk;
    logic    arstN;
    axiReqT  busReq;
    axiRespT busResp;

    // Expected values seen by the checking assertions
    logic [1:0]  expBResp;
    logic [1:0]  expRResp;
    logic [31:0] expRData;

    // Reference model state
    logic [7:0]  expA;
    logic [7:0]  expB;
    logic [7:0]  expResult;
    logic [3:0]  expOp;
    flagsT       expFlags;

    int errCount  = 0;
    int testPass  = 0;
    int testFail  = 0;
    int testStart = 0;
    integer seed  = 32'h9fcc_fc78;

    tbClkGen u_tbClkGen (
        .clk   (clk),
        .arstN (arstN)
    );

    aluTop u_aluTop (
        .clk     (clk),
        .arstN   (arstN),
        .busReq  (busReq),
        .busResp (busResp)
    );

    // ----------------------------------------------------------------------
    // Checking assertions
    // ----------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!arstN)
        busResp.bValid && busReq.bReady |-> busResp.bResp == expBResp)
    else begin
        errCount++;
        $display("[ERROR] %0t: bResp %0h, expected %0h", $time, busResp.bResp, expBResp);
    end

    assert property (@(posedge clk) disable iff (!arstN)
        busResp.rValid && busReq.rReady |->
            busResp.rData == expRData && busResp.rResp == expRResp)
    else begin
        errCount++;
        $display("[ERROR] %0t: rData %0h rResp %0h, expected %0h %0h", $time,
                 busResp.rData, busResp.rResp, expRData, expRResp);
    end

    // Stalled read keeps its data
    assert property (@(posedge clk) disable iff (!arstN)
        busResp.rValid && !busReq.rReady |=> busResp.rValid && $stable(busResp.rData))
    else begin
        errCount++;
        $display("[ERROR] %0t: rData changed while stalled", $time);
    end

    // No second write while a response waits
    assert property (@(posedge clk) disable iff (!arstN)
        busResp.bValid && !busReq.bReady |-> !busResp.awReady)
    else begin
        errCount++;
        $display("[ERROR] %0t: write accepted with response pending", $time);
    end

    // AW and W channels are taken together
    assert property (@(posedge clk) disable iff (!arstN)
        busResp.awReady == busResp.wReady)
    else begin
        errCount++;
        $display("[ERROR] %0t: awReady %0b and wReady %0b differ", $time,
                 busResp.awReady, busResp.wReady);
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic aluRespT refOp(input logic [7:0] a, input logic [7:0] b,
                                      input logic [3:0] op, input flagsT fin);
        logic [8:0] wide;
        logic [7:0] y;
        logic       c;
        logic       v;
        logic       borrow;
        aluRespT    r;
        c      = 1'b0;
        v      = 1'b0;
        y      = '0;
        borrow = !fin.c;
        case (op)
            4'h0, 4'h5: begin
                wide = {1'b0, a} + {1'b0, b} + ((op == 4'h5) ? 9'(fin.c) : 9'd0);
                y    = wide[7:0];
                c    = wide[8];
                v    = (a[7] == b[7]) && (y[7] != a[7]);
            end
            // Carry set when no borrow
            4'h1, 4'h7: begin
                y = a - b;
                c = (a >= b);
                v = (a[7] != b[7]) && (y[7] != a[7]);
            end
            4'h6: begin
                y = a - b - 8'(borrow);
                c = ({1'b0, a} >= ({1'b0, b} + 9'(borrow)));
                v = (a[7] != b[7]) && (y[7] != a[7]);
            end
            4'h2: y = a & b;
            4'h3: y = a | b;
            4'h4: y = a ^ b;
            4'hA: y = ~(a & b);
            4'hB: y = ~(a | b);
            4'hC: y = ~(a ^ b);
            4'h8: begin
                y = {a[6:0], 1'b0};
                c = a[7];
            end
            4'h9: begin
                y = {1'b0, a[7:1]};
                c = a[0];
            end
            4'hD: begin
                y = {a[7], a[7:1]};
                c = a[0];
            end
            default: y = '0;
        endcase
        r.y       = y;
        r.flags.v = v;
        r.flags.n = y[7];
        r.flags.c = c;
        r.flags.z = (y == 8'h00);
        return r;
    endfunction

    function automatic logic [1:0] writeResp(input logic [4:0] addr,
                                             input logic [31:0] data,
                                             input logic [3:0] strb);
        case (addr)
            `REG_A, `REG_B, `REG_FLAGS: return respOkay;
            `REG_CTRL: return (strb[0] && data[3:0] > 4'hD) ? respSlvErr : respOkay;
            default: return respSlvErr;
        endcase
    endfunction

    task automatic updateModel(input logic [4:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        aluRespT r;
        if (strb[0] && writeResp(addr, data, strb) == respOkay) begin
            case (addr)
                `REG_A:     expA     = data[7:0];
                `REG_B:     expB     = data[7:0];
                `REG_FLAGS: expFlags = flagsT'(data[3:0]);
                `REG_CTRL: begin
                    r        = refOp(expA, expB, data[3:0], expFlags);
                    expOp    = data[3:0];
                    expFlags = r.flags;
                    if (data[3:0] != 4'h7) begin
                        expResult = r.y;
                    end
                end
                default: ;
            endcase
        end
    endtask

    // ----------------------------------------------------------------------
    // Bus tasks
    // ----------------------------------------------------------------------
    task automatic axiWrite(input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall);
        int n;
        expBResp = writeResp(addr, data, strb);
        @(posedge clk);
        busReq.awAddr  <= addr;
        busReq.wData   <= data;
        busReq.wStrb   <= strb;
        busReq.awValid <= 1'b1;
        busReq.wValid  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(busResp.awReady && busReq.awValid) && n < TIMEOUT);
        if (busResp.awReady && busReq.awValid) begin
            updateModel(addr, data, strb);
        end else begin
            errCount++;
            $display("Timeout: write to %0h was never accepted", addr);
        end
        busReq.awValid <= 1'b0;
        busReq.wValid  <= 1'b0;
        // Hold off the response
        repeat (stall) @(posedge clk);
        busReq.bReady <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(busResp.bValid && busReq.bReady) && n < TIMEOUT);
        if (!(busResp.bValid && busReq.bReady)) begin
            errCount++;
            $display("Timeout: no write response for %0h", addr);
        end
        busReq.bReady <= 1'b0;
    endtask

    task automatic axiRead(input logic [4:0] addr, input int stall);
        int n;
        expRResp = respOkay;
        case (addr)
            `REG_A:      expRData = 32'(expA);
            `REG_B:      expRData = 32'(expB);
            `REG_CTRL:   expRData = 32'(expOp);
            `REG_RESULT: expRData = 32'(expResult);
            `REG_FLAGS:  expRData = 32'(expFlags);
            default: begin
                expRData = '0;
                expRResp = respSlvErr;
            end
        endcase
        @(posedge clk);
        busReq.arAddr  <= addr;
        busReq.arValid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(busResp.arReady && busReq.arValid) && n < TIMEOUT);
        if (!(busResp.arReady && busReq.arValid)) begin
            errCount++;
            $display("Timeout: read of %0h was never accepted", addr);
        end
        busReq.arValid <= 1'b0;
        repeat (stall) @(posedge clk);
        busReq.rReady <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(busResp.rValid && busReq.rReady) && n < TIMEOUT);
        if (!(busResp.rValid && busReq.rReady)) begin
            errCount++;
            $display("Timeout: no read data for %0h", addr);
        end
        busReq.rReady <= 1'b0;
    endtask

    // Load operands, run one code, read both outputs back
    task automatic runOp(input logic [7:0] a, input logic [7:0] b, input logic [3:0] op);
        axiWrite(`REG_A, 32'(a), 4'hF, 0);
        axiWrite(`REG_B, 32'(b), 4'hF, 0);
        axiWrite(`REG_CTRL, 32'(op), 4'hF, 0);
        axiRead(`REG_RESULT, 0);
        axiRead(`REG_FLAGS, 0);
    endtask

    task automatic endTest(input string name);
        if (errCount == testStart) begin
            testPass++;
            $display("Test %s: pass", name);
        end else begin
            testFail++;
            $display("Test %s: fail, %0d errors", name, errCount - testStart);
        end
        testStart = errCount;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        logic [3:0] arithOps [4];
        logic [3:0] logicOps [9];
        int         n;
        arithOps = '{4'h0, 4'h1, 4'h5, 4'h6};
        logicOps = '{4'h2, 4'h3, 4'h4, 4'hA, 4'hB, 4'hC, 4'h8, 4'h9, 4'hD};
        busReq   <= '0;
        expBResp  = respOkay;
        expRResp  = respOkay;
        expRData  = '0;
        expA      = '0;
        expB      = '0;
        expResult = '0;
        expOp     = 4'h0;
        expFlags  = '0;

        n = 0;
        while (!arstN && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!arstN) begin
            errCount++;
            $display("Timeout: reset never released");
        end

        // 1. Reset state
        assert (!busResp.bValid && !busResp.rValid)
        else begin
            errCount++;
            $display("[ERROR] %0t: response valid after reset", $time);
        end
        axiRead(`REG_A, 0);
        axiRead(`REG_B, 0);
        axiRead(`REG_RESULT, 0);
        axiRead(`REG_FLAGS, 0);
        endTest("reset");

        // 2. Arithmetic, random carry in, then boundaries
        for (int i = 0; i < 24; i++) begin
            axiWrite(`REG_FLAGS, 32'($random(seed) & 2), 4'hF, 0);
            runOp(8'($random(seed)), 8'($random(seed)), arithOps[i % 4]);
        end
        runOp(8'h7F, 8'h01, 4'h0);
        runOp(8'h80, 8'h01, 4'h1);
        runOp(8'hFF, 8'h01, 4'h0);
        endTest("arithmetic");

        // 3. Logic and shifts
        for (int i = 0; i < 27; i++) begin
            runOp(8'($random(seed)), 8'($random(seed)), logicOps[i % 9]);
        end
        runOp(8'hFF, 8'hFF, 4'hB);
        endTest("logic");

        // 4. Compare below, equal, above
        runOp(8'h21, 8'h13, 4'h0);
        runOp(8'h10, 8'h20, 4'h7);
        runOp(8'h55, 8'h55, 4'h7);
        runOp(8'hC0, 8'h05, 4'h7);
        endTest("compare");

        // 5. Bus errors
        runOp(8'h12, 8'h34, 4'h0);
        axiWrite(`REG_CTRL, 32'hE, 4'hF, 0);
        axiRead(`REG_RESULT, 0);
        axiRead(`REG_FLAGS, 0);
        axiRead(`REG_CTRL, 0);
        axiWrite(`REG_RESULT, 32'hAA, 4'hF, 0);
        axiRead(`REG_RESULT, 0);
        axiRead(5'h14, 0);
        axiWrite(`REG_A, 32'hEE, 4'hE, 0);
        axiRead(`REG_A, 0);
        endTest("errors");

        // 6. Second write queued behind a stalled response
        axiWrite(`REG_A, 32'h3C, 4'hF, 0);
        axiWrite(`REG_B, 32'h5A, 4'hF, 0);
        fork
            axiWrite(`REG_CTRL, 32'h0, 4'hF, 3 + ($random(seed) & 7));
            begin
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                end while (!busResp.bValid && n < TIMEOUT);
                if (!busResp.bValid) begin
                    errCount++;
                    $display("Timeout: first write response never raised");
                end
                axiWrite(`REG_CTRL, 32'h4, 4'hF, 0);
            end
        join
        axiRead(`REG_RESULT, 3 + ($random(seed) & 7));
        axiRead(`REG_FLAGS, 3 + ($random(seed) & 7));
        endTest("backpressure");

        $display("Tests passed: %0d, failed: %0d", testPass, testFail);
        if (errCount == 0 && testFail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/aluPkg.sv
hdl/aluArith.sv
hdl/aluLogic.sv
hdl/aluCore.sv
hdl/aluAxiRegs.sv
hdl/aluTop.sv
tb/tbClkGen.sv
tb/aluTopTb.sv

// ==== Makefile ====
# Verilator flow for the ALU coprocessor testbench

VERILATOR ?= verilator
TOP       ?= aluTopTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the log holds the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
